/* logic/intra4_geom_pkg.sv */
// Pixel, edge, block and mode types for 4x4 luma intra prediction.
// Imported by the search RTL, the testbench and the reference model.

`default_nettype none

package intra4_geom_pkg;

    // One 8-bit luma sample
    typedef logic [7:0] pixel_t;

    // Four neighbour pixels, pixel k in bits 8k+7:8k
    typedef pixel_t [3:0] edge_t;

    // 4x4 block, pixel at row y and column x has index y*4+x
    typedef pixel_t [15:0] block_t;

    localparam int NUM_MODES = 4;

    typedef logic [1:0] mode_t;

    localparam mode_t MODE_DC = 2'd0;
    localparam mode_t MODE_TM = 2'd1;
    localparam mode_t MODE_VE = 2'd2;
    localparam mode_t MODE_HE = 2'd3;

    // One enable bit per mode, indexed by mode number
    typedef logic [NUM_MODES-1:0] mode_mask_t;

endpackage

`default_nettype wire

/* logic/intra4_cost_pkg.sv */
// Score arithmetic types, per-mode header costs and configuration map
// for the 4x4 intra mode search.

`default_nettype none

package intra4_cost_pkg;

    typedef logic [15:0] lambda_t;

    // Wide enough for 16 * 255^2
    typedef logic [20:0] sse_t;

    typedef logic [31:0] score_t;

    typedef logic [11:0] fixed_cost_t;

    // Mode signalling cost, indexed by mode number (DC, TM, VE, HE)
    localparam fixed_cost_t FIXED_COST [intra4_geom_pkg::NUM_MODES] = '{
        12'd40, 12'd1151, 12'd1723, 12'd1874
    };

    localparam int SSE_SHIFT = 8;

    // Configuration register map
    typedef logic        cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    localparam cfg_addr_t CFG_ADDR_LAMBDA = 1'b0;
    localparam cfg_addr_t CFG_ADDR_MASK   = 1'b1;

    localparam lambda_t LAMBDA_RESET = 16'd16;

endpackage

`default_nettype wire

/* logic/intra4_predict.sv */
// Combinational 4x4 intra predictor for DC, TrueMotion, vertical and
// horizontal modes. The mode input selects which block is produced.

`timescale 1ns/1ps
`default_nettype none

module intra4_predict (
    input  intra4_geom_pkg::mode_t  mode_i,
    input  intra4_geom_pkg::edge_t  top_i,
    input  intra4_geom_pkg::edge_t  left_i,
    input  intra4_geom_pkg::pixel_t top_left_i,
    output intra4_geom_pkg::block_t pred_o
);

    import intra4_geom_pkg::*;

    logic [10:0] dc_sum;
    pixel_t      dc_val;

    // Saturate a TM sum back into pixel range
    function automatic pixel_t clip8(input logic signed [9:0] v);
        if (v < 0) begin
            return 8'd0;
        end
        if (v > 10'sd255) begin
            return 8'd255;
        end
        return v[7:0];
    endfunction

    // DC is the rounded mean of the eight edge pixels
    always_comb begin
        dc_sum = 11'd4;
        for (int k = 0; k < 4; k++) begin
            dc_sum = dc_sum + 11'(top_i[k]) + 11'(left_i[k]);
        end
    end

    assign dc_val = pixel_t'(dc_sum >> 3);

    always_comb begin
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                case (mode_i)
                    MODE_DC: begin
                        pred_o[y*4+x] = dc_val;
                    end
                    MODE_TM: begin
                        pred_o[y*4+x] = clip8($signed({2'b00, top_i[x]})
                                              + $signed({2'b00, left_i[y]})
                                              - $signed({2'b00, top_left_i}));
                    end
                    MODE_VE: begin
                        // Top row copied straight down, no smoothing
                        pred_o[y*4+x] = top_i[x];
                    end
                    MODE_HE: begin
                        pred_o[y*4+x] = left_i[y];
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/intra4_sse.sv */
// Sum of squared pixel differences between a source block and a
// prediction block, fully combinational.

`timescale 1ns/1ps
`default_nettype none

module intra4_sse (
    input  intra4_geom_pkg::block_t src_i,
    input  intra4_geom_pkg::block_t pred_i,
    output intra4_cost_pkg::sse_t   sse_o
);

    import intra4_geom_pkg::*;
    import intra4_cost_pkg::*;

    pixel_t abs_diff [16];
    sse_t   acc;

    always_comb begin
        acc = '0;
        for (int i = 0; i < 16; i++) begin
            if (src_i[i] > pred_i[i]) begin
                abs_diff[i] = src_i[i] - pred_i[i];
            end else begin
                abs_diff[i] = pred_i[i] - src_i[i];
            end
            acc = acc + sse_t'(abs_diff[i]) * sse_t'(abs_diff[i]);
        end
    end

    assign sse_o = acc;

endmodule

`default_nettype wire

/* logic/intra4_cfg_regs.sv */
// Host-writable configuration for the mode search: lambda and the
// mode-enable mask. Written through a single-cycle write strobe.

`timescale 1ns/1ps
`default_nettype none

module intra4_cfg_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_we_i,
    input  intra4_cost_pkg::cfg_addr_t  cfg_addr_i,
    input  intra4_cost_pkg::cfg_data_t  cfg_wdata_i,
    output intra4_cost_pkg::lambda_t    lambda_o,
    output intra4_geom_pkg::mode_mask_t mode_mask_o
);

    import intra4_geom_pkg::*;
    import intra4_cost_pkg::*;

    lambda_t              lambda_q;
    // DC enable is hard-wired, only the upper mode bits are stored
    logic [NUM_MODES-1:1] mask_hi_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lambda_q  <= LAMBDA_RESET;
            mask_hi_q <= '1;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                CFG_ADDR_LAMBDA: begin
                    lambda_q <= cfg_wdata_i;
                end
                CFG_ADDR_MASK: begin
                    mask_hi_q <= cfg_wdata_i[NUM_MODES-1:1];
                end
                default: begin
                end
            endcase
        end
    end

    assign lambda_o    = lambda_q;
    assign mode_mask_o = {mask_hi_q, 1'b1};

endmodule

`default_nettype wire

/* logic/intra4_mode_search.sv */
// Mode search sequencer. Accepts a block on a req/ack handshake, steps
// the predictor through all four modes, scores each enabled one and
// returns the cheapest mode, its score and its prediction.

`timescale 1ns/1ps
`default_nettype none

module intra4_mode_search (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_i,
    output logic                        ack_o,
    input  intra4_geom_pkg::block_t     src_i,
    input  intra4_geom_pkg::edge_t      top_i,
    input  intra4_geom_pkg::edge_t      left_i,
    input  intra4_geom_pkg::pixel_t     top_left_i,
    input  intra4_cost_pkg::lambda_t    lambda_i,
    input  intra4_geom_pkg::mode_mask_t mode_mask_i,
    input  intra4_cost_pkg::sse_t       sse_i,
    input  intra4_geom_pkg::block_t     pred_i,
    output intra4_geom_pkg::mode_t      mode_o,
    output intra4_geom_pkg::block_t     src_o,
    output intra4_geom_pkg::edge_t      top_o,
    output intra4_geom_pkg::edge_t      left_o,
    output intra4_geom_pkg::pixel_t     top_left_o,
    output intra4_geom_pkg::mode_t      best_mode_o,
    output intra4_cost_pkg::score_t     best_score_o,
    output intra4_geom_pkg::block_t     pred_best_o
);

    import intra4_geom_pkg::*;
    import intra4_cost_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_LATCH, ST_EVAL, ST_ACK} state_t;

    state_t     state;
    mode_t      mode_cnt;
    mode_mask_t mask_q;
    score_t     cand_score;
    logic       cand_better;
    mode_t      run_mode;
    score_t     run_score;
    block_t     run_pred;

    // ------------------------------------------------------------------------
    // Scoring of the mode currently on the predictor
    // ------------------------------------------------------------------------
    assign cand_score = (score_t'(sse_i) << SSE_SHIFT)
                      + score_t'(FIXED_COST[mode_cnt]) * score_t'(lambda_i);

    // Strict compare, so the lower mode number keeps a tie
    assign cand_better = mask_q[mode_cnt] && (cand_score < run_score);

    assign mode_o = mode_cnt;

    // ------------------------------------------------------------------------
    // Control and handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            mode_cnt     <= '0;
            mask_q       <= '0;
            ack_o        <= 1'b0;
            best_mode_o  <= '0;
            best_score_o <= '0;
            pred_best_o  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_i) begin
                        mask_q <= mode_mask_i;
                        state  <= ST_LATCH;
                    end
                end
                ST_LATCH: begin
                    mode_cnt <= '0;
                    state    <= ST_EVAL;
                end
                ST_EVAL: begin
                    mode_cnt <= mode_cnt + 2'd1;
                    if (mode_cnt == mode_t'(NUM_MODES - 1)) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!ack_o) begin
                        ack_o        <= 1'b1;
                        best_mode_o  <= run_mode;
                        best_score_o <= run_score;
                        pred_best_o  <= run_pred;
                    end else if (!req_i) begin
                        ack_o <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Latched block, neighbours and running best
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_i) begin
            src_o      <= src_i;
            top_o      <= top_i;
            left_o     <= left_i;
            top_left_o <= top_left_i;
        end
        if (state == ST_LATCH) begin
            run_score <= '1;
        end else if (state == ST_EVAL && cand_better) begin
            run_mode  <= mode_cnt;
            run_score <= cand_score;
            run_pred  <= pred_i;
        end
    end

endmodule

`default_nettype wire

/* logic/intra4_picker.sv */
// Top level of the 4x4 intra mode picker. Ties the configuration
// registers, the search sequencer, the predictor and the SSE unit.

`timescale 1ns/1ps
`default_nettype none

module intra4_picker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_i,
    output logic                        ack_o,
    input  intra4_geom_pkg::block_t     src_i,
    input  intra4_geom_pkg::edge_t      top_i,
    input  intra4_geom_pkg::edge_t      left_i,
    input  intra4_geom_pkg::pixel_t     top_left_i,
    input  logic                        cfg_we_i,
    input  intra4_cost_pkg::cfg_addr_t  cfg_addr_i,
    input  intra4_cost_pkg::cfg_data_t  cfg_wdata_i,
    output intra4_geom_pkg::mode_t      best_mode_o,
    output intra4_cost_pkg::score_t     best_score_o,
    output intra4_geom_pkg::block_t     pred_o
);

    import intra4_geom_pkg::*;
    import intra4_cost_pkg::*;

    lambda_t    lambda;
    mode_mask_t mode_mask;
    mode_t      cur_mode;
    block_t     src_q;
    edge_t      top_q;
    edge_t      left_q;
    pixel_t     top_left_q;
    block_t     pred_blk;
    sse_t       sse_val;

    intra4_cfg_regs cfg_regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .lambda_o    (lambda),
        .mode_mask_o (mode_mask)
    );

    intra4_mode_search mode_search_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .ack_o        (ack_o),
        .src_i        (src_i),
        .top_i        (top_i),
        .left_i       (left_i),
        .top_left_i   (top_left_i),
        .lambda_i     (lambda),
        .mode_mask_i  (mode_mask),
        .sse_i        (sse_val),
        .pred_i       (pred_blk),
        .mode_o       (cur_mode),
        .src_o        (src_q),
        .top_o        (top_q),
        .left_o       (left_q),
        .top_left_o   (top_left_q),
        .best_mode_o  (best_mode_o),
        .best_score_o (best_score_o),
        .pred_best_o  (pred_o)
    );

    intra4_predict predict_i (
        .mode_i     (cur_mode),
        .top_i      (top_q),
        .left_i     (left_q),
        .top_left_i (top_left_q),
        .pred_o     (pred_blk)
    );

    intra4_sse sse_i (
        .src_i  (src_q),
        .pred_i (pred_blk),
        .sse_o  (sse_val)
    );

endmodule

`default_nettype wire

/* include/intra4_model.svh */
// Reference model of the 4x4 intra mode picker: prediction, SSE and
// best-mode choice. Include inside the testbench after importing
// intra4_geom_pkg and intra4_cost_pkg.

`ifndef INTRA4_MODEL_SVH
`define INTRA4_MODEL_SVH

function automatic block_t predict_block(input mode_t mode, input edge_t top,
                                         input edge_t left, input pixel_t top_left);
    block_t blk;
    int     dc;
    int     tm;
    dc = 4;
    for (int k = 0; k < 4; k++) begin
        dc += int'(top[k]) + int'(left[k]);
    end
    dc = dc >> 3;
    for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
            tm = int'(top[x]) + int'(left[y]) - int'(top_left);
            tm = (tm < 0) ? 0 : ((tm > 255) ? 255 : tm);
            case (mode)
                MODE_DC: blk[y*4+x] = pixel_t'(dc);
                MODE_TM: blk[y*4+x] = pixel_t'(tm);
                MODE_VE: blk[y*4+x] = top[x];
                MODE_HE: blk[y*4+x] = left[y];
            endcase
        end
    end
    return blk;
endfunction

function automatic sse_t block_sse(input block_t src, input block_t pred);
    int acc;
    int d;
    acc = 0;
    for (int i = 0; i < 16; i++) begin
        d = int'(src[i]) - int'(pred[i]);
        acc += d * d;
    end
    return sse_t'(acc);
endfunction

// DC is evaluated whatever the mask holds
function automatic void pick_best_mode(input block_t src, input edge_t top, input edge_t left,
                                       input pixel_t top_left, input lambda_t lambda,
                                       input mode_mask_t mask, output mode_t best_mode,
                                       output score_t best_score, output block_t best_pred);
    block_t pred;
    score_t score;
    best_mode  = MODE_DC;
    best_score = '1;
    best_pred  = '0;
    for (int m = 0; m < NUM_MODES; m++) begin
        if (m == 0 || mask[m]) begin
            pred  = predict_block(mode_t'(m), top, left, top_left);
            score = (score_t'(block_sse(src, pred)) << SSE_SHIFT)
                  + score_t'(FIXED_COST[m]) * score_t'(lambda);
            if (score < best_score) begin
                best_mode  = mode_t'(m);
                best_score = score;
                best_pred  = pred;
            end
        end
    end
endfunction

`endif

/* test/intra4_picker_tb.sv */
// Testbench for the 4x4 intra mode picker. Drives random blocks and
// neighbours through the req/ack handshake, rewrites lambda and the mode
// mask, and compares every result with the reference model.

`timescale 1ns/1ps
`default_nettype none

module intra4_picker_tb;

    import intra4_geom_pkg::*;
    import intra4_cost_pkg::*;

    `include "intra4_model.svh"

    localparam int N_RANDOM    = 200;
    localparam int N_LAMBDA    = 16;
    localparam int N_MASK      = 16;
    localparam int N_HOLD      = 12;
    localparam int N_SEARCH    = 1 + N_RANDOM + N_LAMBDA + N_MASK + 1 + N_HOLD + 1;
    // Hold cycles and config writes are covered by the margin
    localparam int CYCLE_LIMIT = N_SEARCH * 12 + 400;
    localparam int ACK_WAIT    = 16;

    logic       clk;
    logic       rst_n;
    logic       req;
    logic       ack;
    block_t     src;
    edge_t      top_edge;
    edge_t      left_edge;
    pixel_t     top_left;
    logic       cfg_we;
    cfg_addr_t  cfg_addr;
    cfg_data_t  cfg_wdata;
    mode_t      best_mode;
    score_t     best_score;
    block_t     pred;

    logic [31:0] lfsr = 32'h0fe5_52a1;
    lambda_t     cur_lambda;
    mode_mask_t  cur_mask;
    string       cur_test;
    int          errors = 0;
    int          test_start_errors;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    intra4_picker intra4_picker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req),
        .ack_o        (ack),
        .src_i        (src),
        .top_i        (top_edge),
        .left_i       (left_edge),
        .top_left_i   (top_left),
        .cfg_we_i     (cfg_we),
        .cfg_addr_i   (cfg_addr),
        .cfg_wdata_i  (cfg_wdata),
        .best_mode_o  (best_mode),
        .best_score_o (best_score),
        .pred_o       (pred)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Galois LFSR random numbers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic set_random_inputs();
        for (int i = 0; i < 16; i++) begin
            src[i] = pixel_t'(rand_bits(8));
        end
        for (int k = 0; k < 4; k++) begin
            top_edge[k]  = pixel_t'(rand_bits(8));
            left_edge[k] = pixel_t'(rand_bits(8));
        end
        top_left = pixel_t'(rand_bits(8));
    endtask

    // ------------------------------------------------------------------------
    // Checks and reporting
    // ------------------------------------------------------------------------
    task automatic check_val(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
        assert (exp === act) else begin
            $display("FAIL %s %s: expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_start_errors) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, errors - test_start_errors);
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus tasks start and end just after a falling edge
    // ------------------------------------------------------------------------
    task automatic write_cfg(input cfg_addr_t addr, input cfg_data_t data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        @(negedge clk);
        cfg_we = 1'b0;
        if (addr == CFG_ADDR_LAMBDA) begin
            cur_lambda = lambda_t'(data);
        end else begin
            cur_mask = mode_mask_t'(data[NUM_MODES-1:0]);
        end
    endtask

    task automatic run_search(input int hold);
        mode_t  exp_mode;
        score_t exp_score;
        block_t exp_pred;
        int     edges;
        pick_best_mode(src, top_edge, left_edge, top_left, cur_lambda, cur_mask,
                       exp_mode, exp_score, exp_pred);
        req   = 1'b1;
        edges = 0;
        // The first edge accepts and ack is due six edges later
        do begin
            @(posedge clk);
            @(negedge clk);
            edges++;
        end while (!ack && edges < ACK_WAIT);
        assert (ack) else begin
            $display("%s: ack never rose after the request", cur_test);
            errors++;
        end
        check_val("ack latency", 128'(6), 128'(edges - 1));
        check_val("best mode", 128'(exp_mode), 128'(best_mode));
        check_val("best score", 128'(exp_score), 128'(best_score));
        check_val("prediction", 128'(exp_pred), 128'(pred));
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            assert (ack) else begin
                $display("%s: ack dropped while req was still high", cur_test);
                errors++;
            end
            check_val("held mode", 128'(exp_mode), 128'(best_mode));
            check_val("held score", 128'(exp_score), 128'(best_score));
            check_val("held prediction", 128'(exp_pred), 128'(pred));
        end
        req = 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (!ack) else begin
            $display("%s: ack still high one cycle after req dropped", cur_test);
            errors++;
        end
        check_val("kept score", 128'(exp_score), 128'(best_score));
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        pixel_t flat;
        rst_n      = 1'b0;
        req        = 1'b0;
        src        = '0;
        top_edge   = '0;
        left_edge  = '0;
        top_left   = '0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        cur_lambda = LAMBDA_RESET;
        cur_mask   = '1;
        repeat (8) @(posedge clk);
        @(negedge clk);

        begin_test("reset_search");
        assert (!ack) else begin
            $display("%s: ack high during reset", cur_test);
            errors++;
        end
        rst_n = 1'b1;
        set_random_inputs();
        run_search(0);
        end_test();

        begin_test("random_blocks");
        for (int n = 0; n < N_RANDOM; n++) begin
            set_random_inputs();
            run_search(0);
        end
        end_test();

        begin_test("lambda_sweep");
        for (int n = 0; n < N_LAMBDA; n++) begin
            write_cfg(CFG_ADDR_LAMBDA, cfg_data_t'(rand_bits(16)));
            set_random_inputs();
            run_search(0);
        end
        write_cfg(CFG_ADDR_LAMBDA, cfg_data_t'(LAMBDA_RESET));
        end_test();

        begin_test("mask_subset");
        for (int n = 0; n < N_MASK; n++) begin
            write_cfg(CFG_ADDR_MASK, cfg_data_t'(rand_bits(4)));
            set_random_inputs();
            run_search(0);
        end
        write_cfg(CFG_ADDR_MASK, '0);
        set_random_inputs();
        run_search(0);
        check_val("mode with zero mask", 128'(MODE_DC), 128'(best_mode));
        write_cfg(CFG_ADDR_MASK, cfg_data_t'(4'hf));
        end_test();

        begin_test("ack_hold");
        for (int n = 0; n < N_HOLD; n++) begin
            set_random_inputs();
            run_search(int'(rand_bits(3)));
        end
        end_test();

        begin_test("flat_tie");
        flat = pixel_t'(rand_bits(8));
        src       = {16{flat}};
        top_edge  = {4{flat}};
        left_edge = {4{flat}};
        top_left  = flat;
        run_search(0);
        check_val("tie mode", 128'(MODE_DC), 128'(best_mode));
        check_val("tie score", 128'(score_t'(FIXED_COST[0]) * score_t'(cur_lambda)),
                  128'(best_score));
        check_val("tie prediction", 128'({16{flat}}), 128'(pred));
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* intra4_picker.f */
+incdir+include
logic/intra4_geom_pkg.sv
logic/intra4_cost_pkg.sv
logic/intra4_predict.sv
logic/intra4_sse.sv
logic/intra4_cfg_regs.sv
logic/intra4_mode_search.sv
logic/intra4_picker.sv
test/intra4_picker_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
    --top-module intra4_picker_tb -f intra4_picker.f -o intra4_picker_sim

out=$(./obj_dir/intra4_picker_sim)
echo "$out"

if grep -q "^Test passed$" <<< "$out"; then
    exit 0
fi
exit 1
